/* rtl/lrelu_pkg.sv */
package lrelu_pkg;

    localparam int LANES            = 4;   // output words per engine beat
    localparam int MEMBERS          = 4;   // members in one wide input beat
    localparam int WORD_WIDTH_IN    = 24;  // accumulator width
    localparam int WORD_WIDTH_OUT   = 8;   // pixel width
    localparam int WORD_WIDTH_SCALE = 8;
    localparam int SHIFT_WIDTH      = 5;
    localparam int CONFIG_BEATS     = 3;   // header, scale, bias

    // product plus bias, with one bit of headroom for the add
    localparam int SUM_WIDTH = WORD_WIDTH_IN + WORD_WIDTH_SCALE + 1;

    typedef logic signed [WORD_WIDTH_IN-1:0]    acc_t;
    typedef logic signed [WORD_WIDTH_OUT-1:0]   pixel_t;
    typedef logic signed [WORD_WIDTH_SCALE-1:0] scale_t;
    typedef logic        [SHIFT_WIDTH-1:0]      shift_t;
    typedef logic        [1:0]                  member_t;

    localparam pixel_t PIXEL_MAX = pixel_t'(2**(WORD_WIDTH_OUT-1) - 1);
    localparam pixel_t PIXEL_MIN = pixel_t'(-(2**(WORD_WIDTH_OUT-1)));

    typedef enum logic [1:0] {
        PASS,
        BLOCK,
        WRITE_HEADER,
        WRITE_TABLE
    } seq_state_t;

    typedef struct packed {
        acc_t [MEMBERS-1:0][LANES-1:0] words;
        logic                          last;
        logic                          is_1x1;
    } wide_beat_t;

    typedef struct packed {
        acc_t [LANES-1:0] words;
        member_t          member;
        logic             last;
    } lane_beat_t;

    typedef struct packed {
        pixel_t [LANES-1:0] pixels;
        logic               last;
    } pixel_beat_t;

    typedef struct packed {
        shift_t shift;
        shift_t alpha_shift;
        logic   is_1x1;
    } lrelu_cfg_t;

endpackage

/* rtl/config_sequencer.sv */
`timescale 1ns/1ns

module config_sequencer (
    input  logic                  aclk,
    input  logic                  rst_n,
    input  logic                  s_valid,
    output logic                  s_ready,
    input  lrelu_pkg::wide_beat_t s_beat,
    output logic                  dw_valid,
    input  logic                  dw_ready,
    input  logic                  drained,
    output logic                  cfg_write,
    output logic [1:0]            cfg_index
);
    import lrelu_pkg::*;

    seq_state_t state, state_next;
    logic [1:0] cfg_count, cfg_count_next;

    assign cfg_index = cfg_count;   // 0 header, 1 scale, 2 bias

    // steer the slave port
    always_comb begin
        dw_valid  = 1'b0;
        s_ready   = 1'b0;
        cfg_write = 1'b0;
        case (state)
            PASS: begin
                dw_valid = s_valid;
                s_ready  = dw_ready;
            end
            WRITE_HEADER, WRITE_TABLE: begin
                s_ready   = 1'b1;   // table takes a beat every cycle
                cfg_write = s_valid;
            end
            default: begin
                s_ready = 1'b0;     // hold off until the iteration drains
            end
        endcase
    end

    always_comb begin
        state_next     = state;
        cfg_count_next = cfg_count;
        case (state)
            PASS: begin
                if (s_valid && dw_ready && s_beat.last) begin
                    state_next = BLOCK;
                end
            end
            BLOCK: begin
                if (drained) begin
                    state_next = WRITE_HEADER;
                end
            end
            WRITE_HEADER: begin
                if (s_valid) begin
                    state_next     = WRITE_TABLE;
                    cfg_count_next = 2'd1;
                end
            end
            default: begin
                if (s_valid) begin
                    if (cfg_count == 2'(CONFIG_BEATS - 1)) begin
                        state_next     = PASS;
                        cfg_count_next = '0;
                    end else begin
                        cfg_count_next = cfg_count + 2'd1;
                    end
                end
            end
        endcase
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= WRITE_HEADER;
            cfg_count <= '0;
        end else begin
            state     <= state_next;
            cfg_count <= cfg_count_next;
        end
    end

endmodule

/* rtl/member_downsizer.sv */
`timescale 1ns/1ns

module member_downsizer (
    input  logic                  aclk,
    input  logic                  rst_n,
    input  logic                  s_valid,
    output logic                  s_ready,
    input  lrelu_pkg::wide_beat_t s_beat,
    output logic                  m_valid,
    input  logic                  advance,
    output lrelu_pkg::lane_beat_t m_beat
);
    import lrelu_pkg::*;

    acc_t [MEMBERS-1:0][LANES-1:0] words_q;
    logic                          last_q;
    member_t                       member_q;
    logic                          full_q;
    logic                          final_member;
    logic                          take;

    assign final_member = (member_q == member_t'(MEMBERS - 1));

    // accept a new beat when empty or while the final member leaves
    assign s_ready = !full_q || (final_member && advance);
    assign take    = s_valid && s_ready;

    assign m_valid       = full_q;
    assign m_beat.words  = words_q[member_q];
    assign m_beat.member = member_q;
    assign m_beat.last   = last_q && final_member;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            full_q   <= 1'b0;
            member_q <= '0;
        end else begin
            if (full_q && advance) begin
                member_q <= final_member ? member_t'(0) : member_q + member_t'(1);
            end
            if (take) begin
                full_q <= 1'b1;
            end else if (final_member && advance) begin
                full_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (take) begin
            words_q <= s_beat.words;
            last_q  <= s_beat.last;
        end
    end

endmodule

/* rtl/lrelu_lane.sv */
`timescale 1ns/1ns

module lrelu_lane (
    input  logic              aclk,
    input  logic              rst_n,
    input  logic              advance,
    input  lrelu_pkg::acc_t   acc,
    input  lrelu_pkg::scale_t scale,
    input  lrelu_pkg::acc_t   bias,
    input  lrelu_pkg::shift_t shift,
    input  lrelu_pkg::shift_t alpha_shift,
    output lrelu_pkg::pixel_t pixel
);
    import lrelu_pkg::*;

    logic signed [SUM_WIDTH-1:0] prod_q;     // stage 1
    acc_t                        bias_q;
    shift_t                      shift_q;
    shift_t                      alpha1_q;
    logic signed [SUM_WIDTH-1:0] shr_q;      // stage 2
    shift_t                      alpha2_q;
    logic signed [SUM_WIDTH-1:0] leak;
    pixel_t                      sat;
    pixel_t                      pixel_q;    // stage 3

    // negative values get the extra power-of-two slope
    always_comb begin
        leak = shr_q[SUM_WIDTH-1] ? (shr_q >>> alpha2_q) : shr_q;
        if (leak > PIXEL_MAX) begin
            sat = PIXEL_MAX;
        end else if (leak < PIXEL_MIN) begin
            sat = PIXEL_MIN;
        end else begin
            sat = pixel_t'(leak);
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            prod_q   <= '0;
            bias_q   <= '0;
            shift_q  <= '0;
            alpha1_q <= '0;
            shr_q    <= '0;
            alpha2_q <= '0;
            pixel_q  <= '0;
        end else if (advance) begin
            prod_q   <= acc * scale;
            bias_q   <= bias;          // config travels with the data
            shift_q  <= shift;
            alpha1_q <= alpha_shift;
            shr_q    <= (prod_q + bias_q) >>> shift_q;
            alpha2_q <= alpha1_q;
            pixel_q  <= sat;
        end
    end

    assign pixel = pixel_q;

endmodule

/* rtl/lrelu_engine.sv */
`timescale 1ns/1ns

module lrelu_engine (
    input  logic                   aclk,
    input  logic                   rst_n,
    input  logic                   cfg_write,
    input  logic [1:0]             cfg_index,
    input  lrelu_pkg::wide_beat_t  cfg_beat,
    input  logic                   s_valid,
    input  lrelu_pkg::lane_beat_t  s_beat,
    input  logic                   advance,
    output logic                   drained,
    output logic                   m_valid,
    output lrelu_pkg::pixel_beat_t m_beat
);
    import lrelu_pkg::*;

    lrelu_cfg_t                      cfg_q;
    scale_t [MEMBERS-1:0][LANES-1:0] scale_q;
    acc_t   [LANES-1:0]              bias_q;
    member_t                         scale_sel;
    logic   [2:0]                    valid_q;
    logic   [2:0]                    last_q;
    pixel_t [LANES-1:0]              pixels;

    // control part of the config
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_q <= '0;
        end else if (cfg_write && cfg_index == 2'd0) begin
            cfg_q.shift       <= shift_t'(cfg_beat.words[0][0]);
            cfg_q.alpha_shift <= shift_t'(cfg_beat.words[0][1]);
            cfg_q.is_1x1      <= cfg_beat.is_1x1;
        end
    end

    // scale and bias table, simply overwritten each iteration
    always_ff @(posedge aclk) begin
        if (cfg_write && cfg_index == 2'd1) begin
            for (int m = 0; m < MEMBERS; m++) begin
                for (int l = 0; l < LANES; l++) begin
                    scale_q[m][l] <= scale_t'(cfg_beat.words[m][l]);   // low byte
                end
            end
        end
        if (cfg_write && cfg_index == 2'd2) begin
            bias_q <= cfg_beat.words[0];
        end
    end

    assign scale_sel = cfg_q.is_1x1 ? s_beat.member : member_t'(0);

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        lrelu_lane u_lane (
            .aclk        (aclk),
            .rst_n       (rst_n),
            .advance     (advance),
            .acc         (s_beat.words[l]),
            .scale       (scale_q[scale_sel][l]),
            .bias        (bias_q[l]),
            .shift       (cfg_q.shift),
            .alpha_shift (cfg_q.alpha_shift),
            .pixel       (pixels[l])
        );
    end

    // valid and last follow the lane stages
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            last_q  <= '0;
        end else if (advance) begin
            valid_q <= {valid_q[1:0], s_valid};
            last_q  <= {last_q[1:0], s_valid && s_beat.last};
        end
    end

    assign drained       = s_valid && s_beat.last && advance;
    assign m_valid       = valid_q[2];
    assign m_beat.pixels = pixels;
    assign m_beat.last   = last_q[2];

endmodule

/* rtl/output_slice.sv */
`timescale 1ns/1ns

module output_slice (
    input  logic                   aclk,
    input  logic                   rst_n,
    input  logic                   s_valid,
    output logic                   s_ready,
    input  lrelu_pkg::pixel_beat_t s_beat,
    output logic                   m_valid,
    input  logic                   m_ready,
    output lrelu_pkg::pixel_beat_t m_beat
);
    import lrelu_pkg::*;

    pixel_beat_t main_q, spare_q;
    logic        main_valid_q, spare_valid_q;
    logic        load_main;
    logic        fill_spare;

    // main register is free or being emptied this cycle
    assign load_main  = !main_valid_q || m_ready;
    assign fill_spare = s_valid && !spare_valid_q && !load_main;

    assign s_ready = !spare_valid_q;   // straight from a flop
    assign m_valid = main_valid_q;
    assign m_beat  = main_q;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            main_valid_q  <= 1'b0;
            spare_valid_q <= 1'b0;
        end else if (load_main) begin
            main_valid_q  <= spare_valid_q || s_valid;
            spare_valid_q <= 1'b0;
        end else if (fill_spare) begin
            spare_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (load_main) begin
            main_q <= spare_valid_q ? spare_q : s_beat;   // spare drains first
        end
        if (fill_spare) begin
            spare_q <= s_beat;
        end
    end

endmodule

/* rtl/axis_lrelu_engine.sv */
`timescale 1ns/1ns

module axis_lrelu_engine (
    input  logic                   aclk,
    input  logic                   rst_n,
    input  logic                   s_valid,
    output logic                   s_ready,
    input  lrelu_pkg::wide_beat_t  s_beat,
    output logic                   m_valid,
    input  logic                   m_ready,
    output lrelu_pkg::pixel_beat_t m_beat
);
    import lrelu_pkg::*;

    logic        dw_valid, dw_ready;
    logic        cfg_write;
    logic [1:0]  cfg_index;
    logic        lane_valid;
    lane_beat_t  lane_beat;
    logic        advance;   // slice ready, enables every engine stage
    logic        drained;
    logic        eng_valid;
    pixel_beat_t eng_beat;

    config_sequencer u_sequencer (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .s_valid   (s_valid),
        .s_ready   (s_ready),
        .s_beat    (s_beat),
        .dw_valid  (dw_valid),
        .dw_ready  (dw_ready),
        .drained   (drained),
        .cfg_write (cfg_write),
        .cfg_index (cfg_index)
    );

    member_downsizer u_downsizer (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .s_valid (dw_valid),
        .s_ready (dw_ready),
        .s_beat  (s_beat),
        .m_valid (lane_valid),
        .advance (advance),
        .m_beat  (lane_beat)
    );

    lrelu_engine u_engine (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .cfg_write (cfg_write),
        .cfg_index (cfg_index),
        .cfg_beat  (s_beat),      // config beats come in at full width
        .s_valid   (lane_valid),
        .s_beat    (lane_beat),
        .advance   (advance),
        .drained   (drained),
        .m_valid   (eng_valid),
        .m_beat    (eng_beat)
    );

    output_slice u_slice (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .s_valid (eng_valid),
        .s_ready (advance),
        .s_beat  (eng_beat),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .m_beat  (m_beat)
    );

endmodule

/* testbench/tb_axis_lrelu_engine.sv */
`timescale 1ns/1ns

module tb_axis_lrelu_engine;
    import lrelu_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 16;
    localparam int ITERATIONS      = 12;
    localparam int MAX_DATA_BEATS  = 4;
    localparam int MAX_INPUT_BEATS = ITERATIONS * (CONFIG_BEATS + MAX_DATA_BEATS);
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 40 * MAX_INPUT_BEATS;
    localparam int DRAIN_CYCLES    = 40 * MAX_DATA_BEATS;

    logic        aclk;
    logic        rst_n;
    logic        s_valid;
    logic        s_ready;
    wide_beat_t  s_beat;
    logic        m_valid;
    logic        m_ready;
    pixel_beat_t m_beat;

    logic [31:0] lfsr_state;
    pixel_beat_t expected_q[$];   // model output in order
    int          out_count;

    // model copy of the current iteration's configuration
    int          cfg_shift;
    int          cfg_alpha;
    logic        cfg_1x1;
    scale_t      cfg_scale [MEMBERS][LANES];
    acc_t        cfg_bias [LANES];

    axis_lrelu_engine UUT (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .s_beat  (s_beat),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .m_beat  (m_beat)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic acc_t random_acc();
        acc_t value;
        value = acc_t'(random_bits(WORD_WIDTH_IN));
        return value >>> random_bits(4);   // spread the magnitudes
    endfunction

    function automatic wide_beat_t random_wide_beat(input logic mode);
        wide_beat_t beat;
        for (int m = 0; m < MEMBERS; m++) begin
            for (int l = 0; l < LANES; l++) begin
                beat.words[m][l] = random_acc();
            end
        end
        beat.last   = 1'b0;
        beat.is_1x1 = mode;
        return beat;
    endfunction

    // scale, bias, shift, leak, saturate
    function automatic pixel_t expected_pixel(input acc_t acc, input scale_t scale,
                                              input acc_t bias);
        longint value;
        pixel_t result;
        value = longint'(acc) * longint'(scale) + longint'(bias);
        value = value >>> cfg_shift;
        if (value < 0) begin
            value = value >>> cfg_alpha;
        end
        if (value > 127) begin
            result = pixel_t'(127);
        end else if (value < -128) begin
            result = pixel_t'(-128);
        end else begin
            result = pixel_t'(value);
        end
        return result;
    endfunction

    task automatic end_with_failure(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            end_with_failure($sformatf("Fail %s: expected %0h, actual %0h",
                                       name, expected, actual));
        end
    endtask

    task automatic check_output();
        pixel_beat_t expected;
        if (expected_q.size() == 0) begin
            end_with_failure("An output beat arrived when no beat was expected");
        end else begin
            expected = expected_q.pop_front();
            for (int l = 0; l < LANES; l++) begin
                check_equal($sformatf("output %0d lane %0d pixel", out_count, l),
                            32'(expected.pixels[l]), 32'(m_beat.pixels[l]));
            end
            check_equal($sformatf("output %0d last", out_count),
                        32'(expected.last), 32'(m_beat.last));
            out_count++;
        end
    endtask

    // drive on the falling edge and sample both handshakes before the rise
    task automatic run_cycle(input logic valid, input wide_beat_t beat, output logic taken);
        @(negedge aclk);
        s_valid = valid;
        s_beat  = beat;
        m_ready = (random_bits(1) != 0);   // about half the cycles
        #1;
        taken = valid && s_ready;
        if (m_valid && m_ready) begin
            check_output();
        end
    endtask

    task automatic send_beat(input wide_beat_t beat);
        logic taken;
        int   gap;
        gap = 0;
        if (random_bits(1) != 0) begin
            gap = int'(random_bits(2));
        end
        for (int i = 0; i < gap; i++) begin
            run_cycle(1'b0, '0, taken);
        end
        taken = 1'b0;
        while (!taken) begin
            run_cycle(1'b1, beat, taken);
        end
    endtask

    task automatic push_expected(input wide_beat_t beat);
        pixel_beat_t expected;
        int          sel;
        for (int m = 0; m < MEMBERS; m++) begin
            sel = cfg_1x1 ? m : 0;   // 3x3 uses the member 0 scales
            for (int l = 0; l < LANES; l++) begin
                expected.pixels[l] = expected_pixel(beat.words[m][l], cfg_scale[sel][l],
                                                    cfg_bias[l]);
            end
            expected.last = beat.last && (m == MEMBERS - 1);
            expected_q.push_back(expected);
        end
    endtask

    task automatic run_iteration(input int iter);
        wide_beat_t beat;
        logic       mode;
        logic       taken;
        int         data_beats;
        if (iter < 2) begin
            mode = iter[0];   // both modes early on
        end else begin
            mode = (random_bits(1) != 0);
        end
        cfg_1x1   = mode;
        cfg_shift = 4 + int'(random_bits(4));
        cfg_alpha = int'(random_bits(3));

        // header beat with junk above the shift fields
        beat = random_wide_beat(mode);
        beat.words[0][0] = acc_t'((random_bits(19) << SHIFT_WIDTH) | cfg_shift);
        beat.words[0][1] = acc_t'((random_bits(19) << SHIFT_WIDTH) | cfg_alpha);
        send_beat(beat);

        beat = random_wide_beat(mode);
        for (int m = 0; m < MEMBERS; m++) begin
            for (int l = 0; l < LANES; l++) begin
                cfg_scale[m][l] = scale_t'(beat.words[m][l]);   // low byte
            end
        end
        send_beat(beat);

        beat = random_wide_beat(mode);
        for (int l = 0; l < LANES; l++) begin
            cfg_bias[l] = beat.words[0][l];
        end
        send_beat(beat);

        data_beats = 1 + int'(random_bits(2));
        for (int b = 0; b < data_beats; b++) begin
            beat      = random_wide_beat(mode);
            beat.last = (b == data_beats - 1);
            push_expected(beat);
            send_beat(beat);
        end

        // input held off while the iteration drains
        run_cycle(1'b0, '0, taken);
        check_equal($sformatf("iteration %0d s_ready after last", iter), 32'd0, 32'(s_ready));
    endtask

    initial begin
        logic taken;
        lfsr_state = 32'h030a_d398;
        out_count  = 0;
        rst_n      = 1'b0;
        s_valid    = 1'b0;
        s_beat     = '0;
        m_ready    = 1'b0;
        repeat (RESET_CYCLES) @(negedge aclk);
        rst_n = 1'b1;

        run_cycle(1'b0, '0, taken);
        check_equal("m_valid after reset", 32'd0, 32'(m_valid));
        check_equal("s_ready after reset", 32'd1, 32'(s_ready));

        for (int i = 0; i < ITERATIONS; i++) begin
            run_iteration(i);
        end

        for (int i = 0; i < DRAIN_CYCLES && expected_q.size() != 0; i++) begin
            run_cycle(1'b0, '0, taken);
        end
        repeat (20) begin
            run_cycle(1'b0, '0, taken);   // watch for stray beats
        end

        if (expected_q.size() == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            end_with_failure("Expected output beats were never produced");
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        end_with_failure("Timeout: the run did not finish within the allowed cycles");
    end

endmodule

/* axis_lrelu_engine.f */
rtl/lrelu_pkg.sv
rtl/config_sequencer.sv
rtl/member_downsizer.sv
rtl/lrelu_lane.sv
rtl/lrelu_engine.sv
rtl/output_slice.sv
rtl/axis_lrelu_engine.sv
testbench/tb_axis_lrelu_engine.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    --top-module tb_axis_lrelu_engine \
    -f axis_lrelu_engine.f \
    --Mdir obj_dir -o tb_axis_lrelu_engine
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_axis_lrelu_engine)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "^TEST PASSED$"; then
    exit 0
fi

echo "pass line not found in simulation output"
exit 1
